// File: logic/dla_pkg.sv
`default_nettype none

package dla_pkg;

    ////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////
    localparam int TN            = 4;                   // lanes per row
    localparam int FEATURE_WIDTH = 8;
    localparam int DATA_WIDTH    = TN * FEATURE_WIDTH;  // one bus word is one buffer row
    localparam int ADDR_WIDTH    = 16;
    localparam int BUF_ROWS      = 16;
    localparam int ROW_WIDTH     = 4;
    localparam int QUEUE_DEPTH   = 8;
    localparam int RESULT_WIDTH  = 16;
    localparam int ACC_WIDTH     = 20;                  // 4 products plus 16 bit bias

    typedef logic [DATA_WIDTH-1:0]          data_t;
    typedef logic [ADDR_WIDTH-1:0]          addr_t;
    typedef logic [ROW_WIDTH-1:0]           row_t;
    typedef logic [RESULT_WIDTH-1:0]        result_t;
    typedef logic signed [ACC_WIDTH-1:0]    acc_t;

    typedef enum logic [3:0] {
        NOP          = 4'd0,
        LOAD_FEATURE = 4'd1,
        LOAD_WEIGHT  = 4'd2,
        CONFIG       = 4'd3,   // row field holds the shift
        COMPUTE      = 4'd4,
        HALT         = 4'd15
    } opcode_t;

    typedef struct packed {
        opcode_t      opcode;
        row_t         row;
        logic [3:0]   count;
        logic [3:0]   spare;
        logic [15:0]  operand;  // load source or signed bias
    } instr_t;

    ////////////////////////////////////////////////////
    // wishbone classic, read only
    ////////////////////////////////////////////////////
    typedef struct packed {
        logic   cyc;
        logic   stb;
        addr_t  adr;
    } wb_req_t;

    typedef struct packed {
        logic   ack;
        data_t  dat;
    } wb_rsp_t;

    typedef struct packed {
        logic        weight;    // 1 selects weight buffer
        row_t        row;
        logic [3:0]  count;
        addr_t       src;
    } load_cmd_t;

    typedef enum logic [2:0] {
        IDLE, POP, DECODE, WAIT_LOAD, WAIT_COMPUTE, HALTED
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/clp_config.sv
`timescale 1ns/1ps
`default_nettype none

module clp_config
    import dla_pkg::*;
(
    input  wire                  clk,
    input  wire                  i_arst_n,
    input  wire                  i_wr,
    input  wire acc_t            i_bias,
    input  wire [ROW_WIDTH-1:0]  i_shift,
    output acc_t                 o_bias,
    output logic [ROW_WIDTH-1:0] o_shift
);

    // defaults give a plain dot product
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_bias  <= '0;
            o_shift <= '0;
        end else if (i_wr) begin
            o_bias  <= i_bias;
            o_shift <= i_shift;
        end
    end

endmodule

`default_nettype wire

// File: logic/conv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module conv_datapath
    import dla_pkg::*;
(
    input  wire                  clk,
    input  wire                  i_arst_n,
    input  wire                  i_wr,
    input  wire                  i_wr_weight,
    input  wire row_t            i_wr_row,
    input  wire data_t           i_wr_data,
    input  wire                  i_issue,
    input  wire row_t            i_issue_row,
    input  wire acc_t            i_bias,
    input  wire [ROW_WIDTH-1:0]  i_shift,
    output result_t              o_result,
    output logic                 o_result_valid
);

    data_t                               feat_mem [BUF_ROWS];
    data_t                               wgt_mem  [BUF_ROWS];
    data_t                               feat_row;
    data_t                               wgt_row;
    logic signed [2*FEATURE_WIDTH-1:0]   prod_q [TN];   // stage 1 products
    logic                                vld1_q;
    acc_t                                sum;
    acc_t                                shifted;

    always_ff @(posedge clk) begin
        if (i_wr && i_wr_weight)  wgt_mem[i_wr_row]  <= i_wr_data;
        if (i_wr && !i_wr_weight) feat_mem[i_wr_row] <= i_wr_data;
    end

    assign feat_row = feat_mem[i_issue_row];
    assign wgt_row  = wgt_mem[i_issue_row];

    ////////////////////////////////////////////////////
    // stage 1, lane multiplies
    ////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int i = 0; i < TN; i++) begin
            prod_q[i] <= $signed(feat_row[i*FEATURE_WIDTH +: FEATURE_WIDTH]) *
                         $signed(wgt_row[i*FEATURE_WIDTH +: FEATURE_WIDTH]);
        end
    end

    // stage 2 adder tree, bias folded in
    always_comb begin
        sum = i_bias;
        for (int i = 0; i < TN; i++) begin
            sum = sum + acc_t'(prod_q[i]);
        end
    end

    assign shifted = sum >>> i_shift;   // arithmetic, no rounding

    always_ff @(posedge clk) begin
        if (vld1_q) o_result <= shifted[RESULT_WIDTH-1:0];   // wraps, no saturation
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vld1_q         <= 1'b0;
            o_result_valid <= 1'b0;
        end else begin
            vld1_q         <= i_issue;
            o_result_valid <= vld1_q;   // 2 cycles after issue
        end
    end

endmodule

`default_nettype wire

// File: logic/data_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module data_fetch
    import dla_pkg::*;
(
    input  wire             clk,
    input  wire             i_arst_n,
    input  wire             i_start,
    input  wire load_cmd_t  i_cmd,
    output wb_req_t         o_bus,
    input  wire wb_rsp_t    i_bus,
    output logic            o_wr,
    output logic            o_wr_weight,
    output row_t            o_wr_row,
    output data_t           o_wr_data,
    output logic            o_done
);

    logic        cyc_q;
    logic [3:0]  left_q;     // words still to read
    logic        weight_q;
    addr_t       src_q;
    row_t        row_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cyc_q    <= 1'b0;
            left_q   <= '0;
            weight_q <= 1'b0;
            src_q    <= '0;
            row_q    <= '0;
            o_wr     <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            o_wr   <= 1'b0;
            o_done <= 1'b0;
            if (i_start) begin                       // latch new command
                left_q   <= i_cmd.count;
                weight_q <= i_cmd.weight;
                src_q    <= i_cmd.src;
                row_q    <= i_cmd.row;
            end else if (cyc_q && i_bus.ack) begin
                cyc_q  <= 1'b0;
                left_q <= left_q - 1'b1;
                src_q  <= src_q + 1'b1;
                row_q  <= row_q + 1'b1;              // wraps mod 16
                o_wr   <= 1'b1;
                o_done <= (left_q == 4'd1);          // same cycle as last write
            end else if (left_q != '0) begin
                cyc_q <= 1'b1;
            end
        end
    end

    // write payload, taken on ack
    always_ff @(posedge clk) begin
        if (cyc_q && i_bus.ack) begin
            o_wr_weight <= weight_q;
            o_wr_row    <= row_q;
            o_wr_data   <= i_bus.dat;
        end
    end

    assign o_bus = '{cyc: cyc_q, stb: cyc_q, adr: src_q};

endmodule

`default_nettype wire

// File: logic/instr_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_dispatch
    import dla_pkg::*;
(
    input  wire           clk,
    input  wire           i_arst_n,
    input  wire           i_queue_empty,
    input  wire instr_t   i_instr,
    output logic          o_pop,
    output logic          o_flush,
    output logic          o_halt,
    output logic          o_load_start,
    output load_cmd_t     o_load_cmd,
    input  wire           i_load_done,
    output logic          o_cfg_wr,
    output acc_t          o_cfg_bias,
    output logic [ROW_WIDTH-1:0] o_cfg_shift,
    output logic          o_issue,
    output row_t          o_issue_row,
    output logic          o_done
);

    ctrl_state_t         state_q;
    ctrl_state_t         state_d;
    logic [ROW_WIDTH:0]  cmp_cnt_q;   // rows left plus 2 drain cycles
    row_t                row_q;

    ////////////////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////////////////
    always_comb begin
        state_d      = state_q;
        o_pop        = 1'b0;
        o_load_start = 1'b0;
        o_cfg_wr     = 1'b0;
        case (state_q)
            IDLE:      if (!i_queue_empty) state_d = POP;
            POP: begin
                o_pop   = 1'b1;
                state_d = DECODE;                     // word shows up next cycle
            end
            DECODE: begin
                state_d = IDLE;
                case (i_instr.opcode)
                    LOAD_FEATURE, LOAD_WEIGHT: begin
                        if (i_instr.count != '0) begin
                            o_load_start = 1'b1;
                            state_d      = WAIT_LOAD;
                        end
                    end
                    CONFIG:  o_cfg_wr = 1'b1;
                    COMPUTE: if (i_instr.count != '0) state_d = WAIT_COMPUTE;
                    HALT:    state_d = HALTED;
                    NOP:     state_d = IDLE;
                    default: state_d = IDLE;          // unknown codes act as nop
                endcase
            end
            WAIT_LOAD:    if (i_load_done) state_d = IDLE;
            WAIT_COMPUTE: if (cmp_cnt_q == 1) state_d = IDLE;  // last drain cycle
            HALTED:       state_d = HALTED;           // only reset leaves
            default:      state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q   <= IDLE;
            cmp_cnt_q <= '0;
            row_q     <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == DECODE) begin
                cmp_cnt_q <= {1'b0, i_instr.count} + 5'd2;  // pipeline is 2 deep
                row_q     <= i_instr.row;
            end else if (state_q == WAIT_COMPUTE) begin
                cmp_cnt_q <= cmp_cnt_q - 1'b1;
                if (o_issue) row_q <= row_q + 1'b1;           // wraps mod 16
            end
        end
    end

    assign o_issue     = (state_q == WAIT_COMPUTE) && (cmp_cnt_q > 5'd2);
    assign o_issue_row = row_q;

    assign o_load_cmd  = '{weight: (i_instr.opcode == LOAD_WEIGHT), row: i_instr.row,
                           count: i_instr.count, src: i_instr.operand};
    assign o_cfg_bias  = acc_t'($signed(i_instr.operand));  // sign extend
    assign o_cfg_shift = i_instr.row;

    // all results drained before HALT is decoded
    assign o_halt  = (state_q == HALTED);
    assign o_flush = o_halt;
    assign o_done  = o_halt;

endmodule

`default_nettype wire

// File: logic/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch
    import dla_pkg::*;
(
    input  wire          clk,
    input  wire          i_arst_n,
    input  wire          i_start,
    input  wire          i_halt,
    input  wire          i_queue_full,
    output wb_req_t      o_bus,
    input  wire wb_rsp_t i_bus,
    output logic         o_push,
    output instr_t       o_push_data
);

    logic   run_q;  // set by start, cleared by halt
    logic   cyc_q;
    addr_t  pc_q;   // next program word

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            run_q <= 1'b0;
            cyc_q <= 1'b0;
            pc_q  <= '0;
        end else if (i_halt) begin
            run_q <= 1'b0;
            cyc_q <= 1'b0;                      // abort any open read
        end else if (cyc_q) begin
            if (i_bus.ack) begin
                cyc_q <= 1'b0;                  // idle one cycle between reads
                pc_q  <= pc_q + 1'b1;
            end
        end else if (i_start) begin
            run_q <= 1'b1;
            pc_q  <= '0;                        // program starts at word 0
        end else if (run_q && !i_queue_full) begin
            cyc_q <= 1'b1;
        end
    end

    assign o_bus = '{cyc: cyc_q, stb: cyc_q, adr: pc_q};

    // acked word goes straight into the queue
    assign o_push      = cyc_q && i_bus.ack && !i_halt;
    assign o_push_data = instr_t'(i_bus.dat);

endmodule

`default_nettype wire

// File: logic/instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module instr_queue
    import dla_pkg::*;
(
    input  wire         clk,
    input  wire         i_arst_n,
    input  wire         i_push,
    input  wire instr_t i_push_data,
    input  wire         i_pop,
    input  wire         i_flush,
    output instr_t      o_pop_data,
    output logic        o_empty,
    output logic        o_full
);

    instr_t                          mem [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0]  wr_ptr;   // wraps naturally, depth is a power of 2
    logic [$clog2(QUEUE_DEPTH)-1:0]  rd_ptr;
    logic [$clog2(QUEUE_DEPTH):0]    count;
    logic                            do_push;
    logic                            do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;
    assign o_empty = (count == '0);
    assign o_full  = (count == QUEUE_DEPTH[$clog2(QUEUE_DEPTH):0]);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin   // drop everything still queued
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)      count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= i_push_data;
        if (do_pop)  o_pop_data  <= mem[rd_ptr];   // valid the cycle after pop
    end

endmodule

`default_nettype wire

// File: logic/dla_top.sv
`timescale 1ns/1ps
`default_nettype none

module dla_top
    import dla_pkg::*;
(
    input  wire          clk,
    input  wire          i_arst_n,
    input  wire          i_start,
    output wb_req_t      o_ibus,
    input  wire wb_rsp_t i_ibus,
    output wb_req_t      o_dbus,
    input  wire wb_rsp_t i_dbus,
    output result_t      o_result,
    output logic         o_result_valid,
    output logic         o_done
);

    ////////////////////////////////////////////////////
    // instruction path
    ////////////////////////////////////////////////////
    logic                  q_push;
    instr_t                q_push_data;
    logic                  q_pop;
    logic                  q_flush;
    instr_t                q_pop_data;
    logic                  q_empty;
    logic                  q_full;
    logic                  halt;

    // controller to load, config and compute
    logic                  load_start;
    load_cmd_t             load_cmd;
    logic                  load_done;
    logic                  cfg_wr;
    acc_t                  cfg_bias;
    logic [ROW_WIDTH-1:0]  cfg_shift;
    acc_t                  clp_bias;
    logic [ROW_WIDTH-1:0]  clp_shift;
    logic                  issue;
    row_t                  issue_row;

    // buffer write port
    logic                  buf_wr;
    logic                  buf_wr_weight;
    row_t                  buf_wr_row;
    data_t                 buf_wr_data;

    instr_fetch u_ifetch (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_start      (i_start),
        .i_halt       (halt),
        .i_queue_full (q_full),
        .o_bus        (o_ibus),
        .i_bus        (i_ibus),
        .o_push       (q_push),
        .o_push_data  (q_push_data)
    );

    instr_queue u_iqueue (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_push       (q_push),
        .i_push_data  (q_push_data),
        .i_pop        (q_pop),
        .i_flush      (q_flush),
        .o_pop_data   (q_pop_data),
        .o_empty      (q_empty),
        .o_full       (q_full)
    );

    instr_dispatch u_dispatch (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_queue_empty (q_empty),
        .i_instr       (q_pop_data),
        .o_pop         (q_pop),
        .o_flush       (q_flush),
        .o_halt        (halt),
        .o_load_start  (load_start),
        .o_load_cmd    (load_cmd),
        .i_load_done   (load_done),
        .o_cfg_wr      (cfg_wr),
        .o_cfg_bias    (cfg_bias),
        .o_cfg_shift   (cfg_shift),
        .o_issue       (issue),
        .o_issue_row   (issue_row),
        .o_done        (o_done)
    );

    ////////////////////////////////////////////////////
    // data path
    ////////////////////////////////////////////////////
    data_fetch u_dfetch (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_start      (load_start),
        .i_cmd        (load_cmd),
        .o_bus        (o_dbus),
        .i_bus        (i_dbus),
        .o_wr         (buf_wr),
        .o_wr_weight  (buf_wr_weight),
        .o_wr_row     (buf_wr_row),
        .o_wr_data    (buf_wr_data),
        .o_done       (load_done)
    );

    clp_config u_cfg (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_wr      (cfg_wr),
        .i_bias    (cfg_bias),
        .i_shift   (cfg_shift),
        .o_bias    (clp_bias),
        .o_shift   (clp_shift)
    );

    conv_datapath u_clp (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_wr            (buf_wr),
        .i_wr_weight     (buf_wr_weight),
        .i_wr_row        (buf_wr_row),
        .i_wr_data       (buf_wr_data),
        .i_issue         (issue),
        .i_issue_row     (issue_row),
        .i_bias          (clp_bias),
        .i_shift         (clp_shift),
        .o_result        (o_result),
        .o_result_valid  (o_result_valid)
    );

endmodule

`default_nettype wire

// File: tests/tb_dla.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dla
    import dla_pkg::*;
();

    localparam int IMEM_WORDS     = 64;     // program plus queue prefetch fits easily
    localparam int DMEM_WORDS     = 256;
    localparam int RANDOM_INSTRS  = 40;
    // three runs of about 45 instructions with loads of up to ~80 cycles each
    localparam int TIMEOUT_CYCLES = 20000;

    logic         clk;
    logic         arst_n = 1'b0;
    logic         start  = 1'b0;
    wb_req_t      ibus_req;
    wb_rsp_t      ibus_rsp = '0;
    wb_req_t      dbus_req;
    wb_rsp_t      dbus_rsp = '0;
    result_t      result;
    logic         result_valid;
    logic         done;

    logic [31:0]  imem [IMEM_WORDS];
    data_t        dmem [DMEM_WORDS];
    int           prog_len;
    result_t      exp_q [$];               // predicted results in issue order
    int           cycle_cnt = 0;
    logic         ipend = 1'b0;            // instruction read seen and ack pending
    logic [1:0]   iwait = '0;
    logic         dpend = 1'b0;
    logic [1:0]   dwait = '0;

    dla_top dut_i (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_start        (start),
        .o_ibus         (ibus_req),
        .i_ibus         (ibus_rsp),
        .o_dbus         (dbus_req),
        .i_dbus         (dbus_rsp),
        .o_result       (result),
        .o_result_valid (result_valid),
        .o_done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;            // 100 ns period
    end

    //////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("timeout, the run did not finish within the cycle limit");
        end
    end

    //////////////////////////////////////////////////
    // wishbone classic slave memory models
    //////////////////////////////////////////////////
    function automatic logic [31:0] program_word(input addr_t adr);
        if (adr < IMEM_WORDS) return imem[adr];
        else return {HALT, 28'h0};         // past the array reads as HALT
    endfunction

    always @(posedge clk) begin
        if (!(ibus_req.cyc && ibus_req.stb) || ibus_rsp.ack) begin   // idle or ack taken now
            ipend        <= 1'b0;
            ibus_rsp.ack <= 1'b0;
        end else if (!ipend) begin
            ipend <= 1'b1;
            iwait <= 2'($urandom_range(2, 0));     // 1 to 3 cycles in all
        end else if (iwait == 0) begin
            ibus_rsp.ack <= 1'b1;
            ibus_rsp.dat <= program_word(ibus_req.adr);
        end else begin
            iwait <= iwait - 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!(dbus_req.cyc && dbus_req.stb) || dbus_rsp.ack) begin
            dpend        <= 1'b0;
            dbus_rsp.ack <= 1'b0;
        end else if (!dpend) begin
            dpend <= 1'b1;
            dwait <= 2'($urandom_range(2, 0));
        end else if (dwait == 0) begin
            dbus_rsp.ack <= 1'b1;
            dbus_rsp.dat <= dmem[dbus_req.adr[7:0]];   // address wraps over 256 words
        end else begin
            dwait <= dwait - 1'b1;
        end
    end

    // result monitor against the predicted queue
    always @(posedge clk) begin
        if (arst_n && result_valid) begin
            if (exp_q.size() == 0) fail_run("a result appeared when none was expected");
            else check_value("o_result", result, exp_q.pop_front());
        end
    end

    //////////////////////////////////////////////////
    // program building
    //////////////////////////////////////////////////
    task automatic clear_program();
        prog_len = 0;
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = {HALT, 28'h0};
    endtask

    task automatic emit(input opcode_t op, input int row, input int count, input int operand);
        instr_t w;
        w = '{opcode: op, row: row_t'(row), count: 4'(count), spare: 4'h0,
              operand: 16'(operand)};
        imem[prog_len] = w;
        prog_len++;
    endtask

    // fills all 16 rows of both buffers
    task automatic emit_preload();
        emit(LOAD_FEATURE, 0, 15, $urandom_range(65535, 0));
        emit(LOAD_FEATURE, 15, 1, $urandom_range(65535, 0));
        emit(LOAD_WEIGHT, 0, 15, $urandom_range(65535, 0));
        emit(LOAD_WEIGHT, 15, 1, $urandom_range(65535, 0));
    endtask

    task automatic emit_random();
        for (int n = 0; n < RANDOM_INSTRS; n++) begin
            case ($urandom_range(5, 0))
                0: emit(LOAD_FEATURE, $urandom_range(15, 0), $urandom_range(15, 0),
                        $urandom_range(65535, 0));
                1: emit(LOAD_WEIGHT, $urandom_range(15, 0), $urandom_range(15, 0),
                        $urandom_range(65535, 0));
                2: emit(CONFIG, $urandom_range(15, 0), 0, $urandom_range(65535, 0));
                3, 4: emit(COMPUTE, $urandom_range(15, 0), $urandom_range(15, 0), 0);
                default: emit(NOP, 0, 0, 0);
            endcase
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic result_t dot_row(input data_t f, input data_t w, input int bias,
                                        input int shift);
        int sum;
        sum = bias;
        for (int i = 0; i < TN; i++) begin
            sum += int'($signed(f[i*8 +: 8])) * int'($signed(w[i*8 +: 8]));
        end
        sum = sum >>> shift;                   // arithmetic on a signed int
        return result_t'(sum);                 // keep the low 16 bits
    endfunction

    // replays the program up to the first HALT
    task automatic predict_results();
        data_t   feat [BUF_ROWS];
        data_t   wgt  [BUF_ROWS];
        instr_t  w;
        int      bias;
        int      shift;
        addr_t   src;
        row_t    row;
        bias  = 0;                             // reset values of the config block
        shift = 0;
        exp_q.delete();
        for (int i = 0; i < BUF_ROWS; i++) begin
            feat[i] = '0;
            wgt[i]  = '0;
        end
        for (int pc = 0; pc < IMEM_WORDS; pc++) begin
            w = instr_t'(imem[pc]);
            if (w.opcode == HALT) break;
            src = w.operand;
            row = w.row;
            for (int k = 0; k < int'(w.count); k++) begin
                case (w.opcode)
                    LOAD_FEATURE: feat[row] = dmem[src[7:0]];
                    LOAD_WEIGHT:  wgt[row]  = dmem[src[7:0]];
                    COMPUTE:      exp_q.push_back(dot_row(feat[row], wgt[row], bias, shift));
                    default:      ;
                endcase
                src = src + 1'b1;
                row = row + 1'b1;              // wraps mod 16
            end
            if (w.opcode == CONFIG) begin
                bias  = int'($signed(w.operand));
                shift = int'(w.row);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // run sequencing
    //////////////////////////////////////////////////
    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    // everything stays quiet without start
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_value("o_ibus.cyc", ibus_req.cyc, 1'b0);
            check_value("o_ibus.stb", ibus_req.stb, 1'b0);
            check_value("o_dbus.cyc", dbus_req.cyc, 1'b0);
            check_value("o_dbus.stb", dbus_req.stb, 1'b0);
            check_value("o_result_valid", result_valid, 1'b0);
            check_value("o_done", done, 1'b0);
        end
    endtask

    task automatic run_program(input string label);
        predict_results();
        $display("run %s: %0d instructions, %0d results expected",
                 label, prog_len, exp_q.size());
        apply_reset();
        check_idle(6);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (done !== 1'b1) @(posedge clk);  // HALT decoded and results drained
        if (exp_q.size() != 0) begin
            fail_run($sformatf("o_done rose with %0d results still missing", exp_q.size()));
        end
        repeat (16) begin                      // quiet after halt
            @(posedge clk);
            check_value("o_result_valid", result_valid, 1'b0);
            check_value("o_ibus.cyc", ibus_req.cyc, 1'b0);
            check_value("o_done", done, 1'b1);
        end
    endtask

    initial begin
        void'($urandom(12));
        for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = data_t'($urandom());

        // plain dot products with default config
        clear_program();
        emit_preload();
        emit(COMPUTE, 0, 15, 0);
        emit(COMPUTE, 15, 1, 0);
        emit(HALT, 0, 0, 0);
        run_program("dot products");

        // config changes between computes
        clear_program();
        emit_preload();
        emit(COMPUTE, 2, 6, 0);
        emit(CONFIG, 3, 0, $urandom_range(65535, 0));
        emit(COMPUTE, 2, 6, 0);
        emit(CONFIG, 7, 0, -500);              // negative bias
        emit(COMPUTE, 13, 7, 0);               // wraps past row 15
        emit(NOP, 0, 0, 0);
        emit(COMPUTE, 5, 0, 0);                // count 0 gives nothing
        emit(HALT, 0, 0, 0);
        run_program("config");

        // mixed random program
        clear_program();
        emit_preload();
        emit_random();
        emit(HALT, 0, 0, 0);
        run_program("random");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/dla_pkg.sv
logic/clp_config.sv
logic/conv_datapath.sv
logic/data_fetch.sv
logic/instr_dispatch.sv
logic/instr_fetch.sv
logic/instr_queue.sv
logic/dla_top.sv
tests/tb_dla.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dla -f filelist.f -o sim_tb_dla

output=$(./obj_dir/sim_tb_dla 2>&1) || true
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
